// File: src/audio_pkg.sv
/* Audio mixer shared definitions */

package audio_pkg;

    // Address map, regions matched on address bits 15:8
    localparam logic [15:0] ADDR_BASE  = 16'h6000;
    localparam logic [15:0] REG_COEF   = ADDR_BASE + 16'h0000;
    localparam logic [15:0] REG_RESULT = ADDR_BASE + 16'h0100;
    localparam logic [15:0] REG_STATUS = ADDR_BASE + 16'h0200;
    localparam logic [15:0] REG_RESET  = ADDR_BASE + 16'h0300;
    localparam logic [15:0] REG_INPUT  = ADDR_BASE + 16'h0400;
    localparam logic [15:0] REG_TEST   = ADDR_BASE + 16'h0500;

    // Sizes
    localparam int CHANNELS     = 16;
    localparam int FRAMES       = 32;
    localparam int CODE         = 256;
    localparam int OUT_CHANNELS = 16;
    localparam int TEST_WORDS   = 32;

    localparam int CHAN_W  = $clog2(CHANNELS);
    localparam int FRAME_W = $clog2(FRAMES);
    localparam int CODE_W  = $clog2(CODE);
    localparam int AUDIO_W = $clog2(CHANNELS * FRAMES);

    typedef logic signed [15:0] sample_t;
    typedef logic [31:0]        word_t;
    typedef logic signed [39:0] acc_t;

    typedef enum logic [1:0] {
        op_bad  = 2'd0,
        op_mac  = 2'd1,
        op_save = 2'd2,
        op_halt = 2'd3
    } op_t;

    // Accumulator is scaled down by this much on save
    localparam int GAIN_SHIFT = 14;

    // Instruction fields
    localparam int OP_HI   = 31;
    localparam int OP_LO   = 30;
    localparam int IN_HI   = 27;
    localparam int IN_LO   = 24;
    localparam int OUT_HI  = 19;
    localparam int OUT_LO  = 16;
    localparam int GAIN_HI = 15;
    localparam int GAIN_LO = 0;

endpackage

// File: src/dpram.sv
/* Dual-port RAM */

module dpram #(
    parameter type word_type = logic [31:0],
    parameter int  DEPTH     = 256
) (
    input  logic                     ck,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_type                 wdata,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_type                 rdata
);

    word_type mem [DEPTH];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Zero when idle so several read ports can be ORed together
        if (re) begin
            rdata <= mem[raddr];
        end else begin
            rdata <= '0;
        end
    end

    assert property (@(posedge ck) we |-> (int'(waddr) < DEPTH));

endmodule

// File: src/iomem_decode.sv
/* Bus region decoder */

module iomem_decode #(
    parameter logic [15:0] REGION = audio_pkg::ADDR_BASE
) (
    input  logic        ck,
    input  logic        rst_n,
    input  logic        valid,
    input  logic [3:0]  wstrb,
    input  logic [15:0] addr,
    output logic        ready,
    output logic        we,
    output logic        re
);

    logic hit;
    logic acked;

    assign hit = valid && (addr[15:8] == REGION[15:8]) && !acked;
    assign we  = hit && (wstrb != 4'h0);
    assign re  = hit && (wstrb == 4'h0);

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            acked <= 1'b0;
            ready <= 1'b0;
        end else begin
            ready <= we || re;
            // Hold off until the host drops valid
            if (!valid) begin
                acked <= 1'b0;
            end else if (hit) begin
                acked <= 1'b1;
            end
        end
    end

    assert property (@(posedge ck) disable iff (!rst_n) !(we && re));

endmodule

// File: src/engine_timer.sv
/* Engine reset stretch and run timer */

module engine_timer (
    input  logic              ck,
    input  logic              rst_n,
    input  logic              start_req,
    input  logic              busy,
    output logic              engine_rst,
    output audio_pkg::word_t  run_cycles
);

    logic [1:0] stretch;

    // Counts up to 3 after each request, engine held in reset meanwhile
    always_ff @(posedge ck) begin
        if (!rst_n || start_req) begin
            stretch <= 2'b00;
        end else if (stretch != 2'b11) begin
            stretch <= stretch + 2'b01;
        end
    end

    assign engine_rst = (stretch != 2'b11);

    // Cycles spent running the last program
    always_ff @(posedge ck) begin
        if (!rst_n || engine_rst) begin
            run_cycles <= '0;
        end else if (busy) begin
            run_cycles <= run_cycles + 32'd1;
        end
    end

endmodule

// File: src/sequencer.sv
/* Mixing program sequencer */

module sequencer (
    input  logic                            ck,
    input  logic                            engine_rst,
    input  logic [audio_pkg::FRAME_W-1:0]   frame,
    output logic [audio_pkg::CODE_W-1:0]    coef_raddr,
    input  audio_pkg::word_t                coef_rdata,
    output logic [audio_pkg::AUDIO_W-1:0]   audio_raddr,
    output logic                            op_valid,
    output logic                            op_save,
    output logic                            acc_clear,
    output audio_pkg::sample_t              gain,
    output logic [audio_pkg::CHAN_W-1:0]    out_addr,
    output logic                            out_we,
    output logic                            busy,
    output logic                            done,
    output logic                            error
);

    import audio_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_sample,
        st_execute,
        st_halted
    } state_t;

    state_t            state;
    logic [CODE_W-1:0] pc;
    op_t               op;
    logic              exec;
    logic              last_word;

    // Instruction word stays on the RAM output from sample through execute
    assign op        = op_t'(coef_rdata[OP_HI:OP_LO]);
    assign exec      = (state == st_execute);
    assign last_word = (pc == CODE_W'(CODE - 1));

    assign coef_raddr  = pc;
    assign audio_raddr = {frame, coef_rdata[IN_HI:IN_LO]};
    assign gain        = sample_t'(coef_rdata[GAIN_HI:GAIN_LO]);
    assign out_addr    = coef_rdata[OUT_HI:OUT_LO];

    // Datapath strobes
    assign op_save   = exec && (op == audio_pkg::op_save);
    assign op_valid  = exec && ((op == audio_pkg::op_mac) || (op == audio_pkg::op_save));
    assign out_we    = op_save;
    assign acc_clear = engine_rst || op_save;

    assign busy = (state == st_fetch) || (state == st_sample) || exec;

    always_ff @(posedge ck) begin
        if (engine_rst) begin
            state <= st_idle;
            pc    <= '0;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            case (state)
                st_idle:   state <= st_fetch;
                st_fetch:  state <= st_sample;
                st_sample: state <= st_execute;
                st_execute: begin
                    case (op)
                        audio_pkg::op_mac, audio_pkg::op_save: begin
                            if (last_word) begin
                                // Ran off the end of the program
                                error <= 1'b1;
                                done  <= 1'b1;
                                state <= st_halted;
                            end else begin
                                pc    <= pc + 1'b1;
                                state <= st_fetch;
                            end
                        end
                        audio_pkg::op_halt: begin
                            done  <= 1'b1;
                            state <= st_halted;
                        end
                        default: begin
                            error <= 1'b1;
                            done  <= 1'b1;
                            state <= st_halted;
                        end
                    endcase
                end
                st_halted: state <= st_halted;
                default:   state <= st_idle;
            endcase
        end
    end

    assert property (@(posedge ck) disable iff (engine_rst)
        out_we |-> (exec && $past(state) == st_sample));

endmodule

// File: src/mix_datapath.sv
/* Multiply-accumulate mixing datapath */

module mix_datapath (
    input  logic                ck,
    input  logic                rst_n,
    input  logic                op_valid,
    input  logic                op_save,
    input  logic                acc_clear,
    input  audio_pkg::sample_t  gain,
    input  audio_pkg::sample_t  sample,
    output audio_pkg::acc_t     acc,
    output audio_pkg::sample_t  out_sample
);

    import audio_pkg::*;

    localparam acc_t SAT_MAX = 40'sd32767;
    localparam acc_t SAT_MIN = -40'sd32768;

    acc_t product;
    acc_t scaled;

    // Both operands signed, so the product is sign extended to 40 bits
    assign product = gain * sample;

    always_ff @(posedge ck) begin
        if (!rst_n || acc_clear) begin
            acc <= '0;
        end else if (op_valid && !op_save) begin
            acc <= acc + product;
        end
    end

    assign scaled = acc >>> GAIN_SHIFT;

    // Clip to the sample range
    always_comb begin
        if (scaled > SAT_MAX) begin
            out_sample = 16'sh7fff;
        end else if (scaled < SAT_MIN) begin
            out_sample = -16'sh8000;
        end else begin
            out_sample = scaled[15:0];
        end
    end

endmodule

// File: src/audio_engine.sv
/* Audio mixing peripheral */

module audio_engine (
    input  logic              ck,
    input  logic              rst_n,
    input  logic              iomem_valid,
    input  logic [3:0]        iomem_wstrb,
    input  logic [31:0]       iomem_addr,
    input  audio_pkg::word_t  iomem_wdata,
    output logic              iomem_ready,
    output audio_pkg::word_t  iomem_rdata
);

    import audio_pkg::*;

    logic coef_we, coef_ready;
    logic result_re, result_ready;
    logic status_we, status_re, status_ready;
    logic reset_we, reset_ready;
    logic input_we, input_ready;
    logic test_we, test_re, test_ready;

    logic               allow_writes;
    logic [FRAME_W-1:0] frame;
    word_t              rd_status;

    logic engine_rst, busy, done, error;
    word_t run_cycles;

    logic [CODE_W-1:0]  coef_raddr;
    word_t              coef_rdata;
    logic [AUDIO_W-1:0] audio_raddr;
    sample_t            audio_rdata;

    logic op_valid, op_save, acc_clear, out_we;
    sample_t gain, out_sample, result_rdata;
    logic [CHAN_W-1:0] out_addr;
    word_t test_rdata;

    // One decoder per region
    iomem_decode #(.REGION(REG_COEF)) coef_io (.ck, .rst_n, .valid(iomem_valid),
        .wstrb(iomem_wstrb), .addr(iomem_addr[15:0]), .ready(coef_ready), .we(coef_we), .re());
    iomem_decode #(.REGION(REG_RESULT)) result_io (.ck, .rst_n, .valid(iomem_valid),
        .wstrb(iomem_wstrb), .addr(iomem_addr[15:0]), .ready(result_ready), .we(), .re(result_re));
    iomem_decode #(.REGION(REG_STATUS)) status_io (.ck, .rst_n, .valid(iomem_valid),
        .wstrb(iomem_wstrb), .addr(iomem_addr[15:0]), .ready(status_ready), .we(status_we),
        .re(status_re));
    iomem_decode #(.REGION(REG_RESET)) reset_io (.ck, .rst_n, .valid(iomem_valid),
        .wstrb(iomem_wstrb), .addr(iomem_addr[15:0]), .ready(reset_ready), .we(reset_we), .re());
    iomem_decode #(.REGION(REG_INPUT)) input_io (.ck, .rst_n, .valid(iomem_valid),
        .wstrb(iomem_wstrb), .addr(iomem_addr[15:0]), .ready(input_ready), .we(input_we), .re());
    iomem_decode #(.REGION(REG_TEST)) test_io (.ck, .rst_n, .valid(iomem_valid),
        .wstrb(iomem_wstrb), .addr(iomem_addr[15:0]), .ready(test_ready), .we(test_we),
        .re(test_re));

    // Program store, written by the host and read by the sequencer
    dpram #(.word_type(word_t), .DEPTH(CODE)) coef_ram (.ck, .we(coef_we),
        .waddr(iomem_addr[CODE_W+1:2]), .wdata(iomem_wdata), .re(1'b1),
        .raddr(coef_raddr), .rdata(coef_rdata));

    // Input samples, indexed by {frame, channel}
    dpram #(.word_type(sample_t), .DEPTH(CHANNELS * FRAMES)) audio_ram (.ck,
        .we(input_we && allow_writes), .waddr(iomem_addr[AUDIO_W+1:2]),
        .wdata(sample_t'(iomem_wdata[15:0])), .re(1'b1), .raddr(audio_raddr),
        .rdata(audio_rdata));

    dpram #(.word_type(sample_t), .DEPTH(OUT_CHANNELS)) result_ram (.ck, .we(out_we),
        .waddr(out_addr), .wdata(out_sample), .re(result_re),
        .raddr(iomem_addr[$clog2(OUT_CHANNELS)+1:2]), .rdata(result_rdata));

    dpram #(.word_type(word_t), .DEPTH(TEST_WORDS)) test_ram (.ck, .we(test_we),
        .waddr(iomem_addr[$clog2(TEST_WORDS)+1:2]), .wdata(iomem_wdata), .re(test_re),
        .raddr(iomem_addr[$clog2(TEST_WORDS)+1:2]), .rdata(test_rdata));

    engine_timer timer (.ck, .rst_n, .start_req(reset_we), .busy, .engine_rst, .run_cycles);

    sequencer seq (.ck, .engine_rst, .frame, .coef_raddr, .coef_rdata, .audio_raddr,
        .op_valid, .op_save, .acc_clear, .gain, .out_addr, .out_we, .busy, .done, .error);

    mix_datapath mix (.ck, .rst_n, .op_valid, .op_save, .acc_clear, .gain,
        .sample(audio_rdata), .acc(), .out_sample);

    // Control register: bit 0 allow_writes, bits 5:1 frame
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            allow_writes <= 1'b0;
            frame        <= '0;
        end else if (status_we && !iomem_addr[2]) begin
            allow_writes <= iomem_wdata[0];
            frame        <= iomem_wdata[FRAME_W:1];
        end
    end

    always_ff @(posedge ck) begin
        if (!status_re) begin
            rd_status <= '0;
        end else if (iomem_addr[2]) begin
            rd_status <= run_cycles;
        end else begin
            rd_status <= {24'h0, frame, error, done, allow_writes};
        end
    end

    assign iomem_rdata = {16'h0, result_rdata} | rd_status | test_rdata;
    assign iomem_ready = coef_ready | result_ready | status_ready | reset_ready
                       | input_ready | test_ready;

endmodule

// File: verification/audio_engine_tb.sv
/* Audio engine testbench */

module audio_engine_tb;

    import audio_pkg::*;

    localparam int BUS_TIMEOUT  = 50;
    localparam int POLL_TIMEOUT = 200;

    logic        ck;
    logic        rst_n;
    logic        iomem_valid;
    logic [3:0]  iomem_wstrb;
    logic [31:0] iomem_addr;
    word_t       iomem_wdata;
    logic        iomem_ready;
    word_t       iomem_rdata;

    logic [31:0] lfsr;
    int          sample_errors;
    int          word_errors;
    int          status_errors;
    int          timeouts;

    // Reference state mirrored from host writes
    word_t              prog_model [64];
    sample_t            audio_model [FRAMES][CHANNELS];
    sample_t            result_model [OUT_CHANNELS];
    logic               saved [OUT_CHANNELS];
    word_t              test_model [TEST_WORDS];
    logic               allow_model;
    logic [FRAME_W-1:0] frame_model;

    audio_engine audio_engine_i (.ck, .rst_n, .iomem_valid, .iomem_wstrb, .iomem_addr,
        .iomem_wdata, .iomem_ready, .iomem_rdata);

    always #2 ck = ~ck;

    // Taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t random_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic sample_t pick_sample(input logic extreme);
        if (extreme) begin
            return random_bits(1) ? 16'sh7fff : 16'sh8000;
        end
        return sample_t'(random_bits(16));
    endfunction

    function automatic word_t encode(input op_t op, input int in_ch, input int out_ch,
                                     input sample_t g);
        return {op, 2'b00, 4'(in_ch), 4'b0000, 4'(out_ch), g};
    endfunction

    // Q14 gain scaling, then clip to the 16-bit sample range
    function automatic sample_t saturate(input acc_t a);
        acc_t s;
        s = a >>> GAIN_SHIFT;
        if (s > 40'sd32767) begin
            return 16'sh7fff;
        end
        if (s < -40'sd32768) begin
            return 16'sh8000;
        end
        return s[15:0];
    endfunction

    task automatic finish_run;
        $display("errors: %0d sample, %0d word, %0d status, %0d timeout",
            sample_errors, word_errors, status_errors, timeouts);
        if (sample_errors + word_errors + status_errors + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            sample_errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_status(input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t: status is %h, expected %h", $time, got, exp);
            status_errors++;
        end
    endtask

    task automatic wait_ready;
        int n;
        n = 0;
        do begin
            @(posedge ck);
            n++;
        end while (!iomem_ready && n < BUS_TIMEOUT);
        if (!iomem_ready) begin
            $display("bus never answered the access to address %h", iomem_addr);
            timeouts++;
        end
    endtask

    task automatic bus_write(input word_t addr, input word_t data);
        @(posedge ck);
        iomem_valid <= 1'b1;
        iomem_wstrb <= 4'hf;
        iomem_addr  <= addr;
        iomem_wdata <= data;
        wait_ready();
        iomem_valid <= 1'b0;
        iomem_wstrb <= 4'h0;
    endtask

    task automatic bus_read(input word_t addr, output word_t data);
        @(posedge ck);
        iomem_valid <= 1'b1;
        iomem_wstrb <= 4'h0;
        iomem_addr  <= addr;
        wait_ready();
        data = iomem_rdata;
        iomem_valid <= 1'b0;
    endtask

    task automatic set_control(input logic [FRAME_W-1:0] frame, input logic allow);
        bus_write(REG_STATUS, {26'h0, frame, allow});
        frame_model = frame;
        allow_model = allow;
    endtask

    // Only frames 16 to 19 fall inside the input window
    task automatic load_sample(input int ch, input sample_t value);
        bus_write(REG_INPUT + ((int'(frame_model) % 4) * CHANNELS + ch) * 4,
            word_t'(signed'(value)));
        if (allow_model) begin
            audio_model[frame_model][ch] = value;
        end
    endtask

    task automatic load_program(input int len);
        for (int i = 0; i < len; i++) begin
            bus_write(REG_COEF + i * 4, prog_model[i]);
        end
    endtask

    // Body of MACs and SAVEs, the last body word always a SAVE
    task automatic random_program(input int len, input logic extreme, input op_t last_op);
        op_t op;
        for (int k = 0; k < len; k++) begin
            op = (k == len - 1 || random_bits(2) == 0) ? op_save : op_mac;
            prog_model[k] = encode(op, random_bits(4), random_bits(4), pick_sample(extreme));
        end
        prog_model[len] = encode(last_op, 0, 0, sample_t'(random_bits(16)));
        prog_model[len + 1] = encode(op_halt, 0, 0, 16'sh0000);
        load_program(len + 2);
    endtask

    task automatic run_and_check;
        word_t status;
        word_t rd;
        word_t instr;
        acc_t  acc;
        logic  err;
        int    pc;
        int    n;
        acc = '0;
        err = 1'b0;
        foreach (saved[i]) begin
            saved[i] = 1'b0;
        end
        // Step through the program the way the engine would
        for (pc = 0; pc < 64; pc++) begin
            instr = prog_model[pc];
            case (op_t'(instr[OP_HI:OP_LO]))
                op_mac: acc += acc_t'(sample_t'(instr[GAIN_HI:GAIN_LO]))
                             * acc_t'(audio_model[frame_model][instr[IN_HI:IN_LO]]);
                op_save: begin
                    result_model[instr[OUT_HI:OUT_LO]] = saturate(acc);
                    saved[instr[OUT_HI:OUT_LO]] = 1'b1;
                    acc = '0;
                end
                op_halt: break;
                default: begin
                    err = 1'b1;
                    break;
                end
            endcase
        end
        bus_write(REG_RESET, '0);
        n = 0;
        do begin
            bus_read(REG_STATUS, status);
            n++;
        end while (!status[1] && n < POLL_TIMEOUT);
        if (!status[1]) begin
            $display("engine did not report done after %0d polls", n);
            timeouts++;
        end else begin
            check_status(status, {24'h0, frame_model, err, 1'b1, allow_model});
            bus_read(REG_STATUS + 4, rd);
            check_word("run_cycles", rd, 3 * (pc + 1));
            for (int ch = 0; ch < OUT_CHANNELS; ch++) begin
                if (saved[ch]) begin
                    bus_read(REG_RESULT + ch * 4, rd);
                    check_sample($sformatf("result[%0d]", ch), rd[15:0], result_model[ch]);
                end
            end
        end
    endtask

    initial begin
        int    order [TEST_WORDS];
        int    j;
        int    t;
        word_t rd;
        lfsr          = 32'h5d9d;
        ck            = 1'b0;
        rst_n         = 1'b0;
        iomem_valid   = 1'b0;
        iomem_wstrb   = 4'h0;
        iomem_addr    = '0;
        iomem_wdata   = '0;
        sample_errors = 0;
        word_errors   = 0;
        status_errors = 0;
        timeouts      = 0;
        allow_model   = 1'b0;
        frame_model   = '0;
        repeat (4) @(posedge ck);
        rst_n <= 1'b1;

        // Test RAM written in order, read back shuffled
        for (int i = 0; i < TEST_WORDS; i++) begin
            test_model[i] = random_bits(32);
            bus_write(REG_TEST + i * 4, test_model[i]);
            order[i] = i;
        end
        for (int i = TEST_WORDS - 1; i > 0; i--) begin
            j = random_bits(8) % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < TEST_WORDS; i++) begin
            bus_read(REG_TEST + order[i] * 4, rd);
            check_word($sformatf("test[%0d]", order[i]), rd, test_model[order[i]]);
        end

        // A blocked input write leaves the earlier sample in place
        set_control(5'd17, 1'b1);
        load_sample(3, 16'sh1234);
        set_control(5'd17, 1'b0);
        load_sample(3, 16'sh4321);
        prog_model[0] = encode(op_mac, 3, 0, 16'sh4000);
        prog_model[1] = encode(op_save, 0, 5, 16'sh0000);
        prog_model[2] = encode(op_halt, 0, 0, 16'sh0000);
        load_program(3);
        run_and_check();
        set_control(5'd17, 1'b1);
        load_sample(3, 16'sh4321);
        run_and_check();

        // Random mixes, odd runs pushed to full scale for saturation
        for (int r = 0; r < 6; r++) begin
            set_control(5'(16 + random_bits(2)), 1'b1);
            for (int c = 0; c < CHANNELS; c++) begin
                load_sample(c, pick_sample(r % 2 == 1));
            end
            random_program(4 + random_bits(5), r % 2 == 1, op_halt);
            run_and_check();
        end

        // Illegal opcode stops the run with an error
        random_program(6, 1'b0, op_bad);
        run_and_check();

        finish_run();
    end

endmodule

// File: audio_engine.f
src/audio_pkg.sv
src/dpram.sv
src/iomem_decode.sv
src/engine_timer.sv
src/sequencer.sv
src/mix_datapath.sv
src/audio_engine.sv
verification/audio_engine_tb.sv
